// File: source/xv_bus_pkg.sv
// host register numbers, bus direction, control and status bit positions, memory op enum
`default_nettype none

package xv_bus_pkg;

    // host register numbers on bus_reg_num_i
    typedef enum logic [3:0] {
        XR_WR_ADDR = 4'h0,      // vram write address
        XR_DATA    = 4'h1,      // vram write data then write address + 1
        XR_RD_ADDR = 4'h2,      // vram read address, odd byte starts read
        XR_RD_DATA = 4'h3,      // latched read result
        XR_PAL     = 4'h4,      // index in 15:12, colour in 11:0
        XR_CTRL    = 4'h5,      // video enable and irq acknowledge
        XR_STATUS  = 4'h6       // busy and vblank
    } xv_reg_e;

    typedef enum logic {
        BUS_WR = 1'b0,
        BUS_RD = 1'b1
    } bus_rnw_e;

    // pending vram operation in the register block
    typedef enum logic {
        MOP_READ  = 1'b0,
        MOP_WRITE = 1'b1
    } mem_op_e;

    localparam int CTRL_ENA_BIT    = 0;
    localparam int CTRL_IACK_BIT   = 1;
    localparam int STAT_BUSY_BIT   = 0;
    localparam int STAT_VBLANK_BIT = 1;

endpackage

`default_nettype wire

// File: source/xv_video_pkg.sv
// scan phase enum and pixel index / palette colour widths
`default_nettype none

package xv_video_pkg;

    // phase of a horizontal or vertical scan counter
    typedef enum logic [1:0] {
        SP_VISIBLE = 2'd0,
        SP_FRONT   = 2'd1,      // front porch
        SP_SYNC    = 2'd2,
        SP_BACK    = 2'd3       // back porch
    } scan_phase_e;

    localparam int PIX_W   = 4;     // bits per pixel index
    localparam int COLOR_W = 12;    // 4 bits each of r, g, b

endpackage

`default_nettype wire

// File: source/xv_regs.sv
// host register block with byte assembly, vram request handshake, palette strobe, control
`default_nettype none
`timescale 1ns/10ps

module xv_regs
    import xv_bus_pkg::*;
    import xv_video_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   bus_cs_n_i,     // select strobe, active low
    input  wire logic                   bus_rd_nwr_i,
    input  wire logic [3:0]             bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 even byte (15:8)
    input  wire logic [7:0]             bus_data_i,
    input  wire logic                   mem_ack_i,
    input  wire logic [15:0]            mem_rdata_i,
    input  wire logic                   vblank_i,
    input  wire logic                   vblank_start_i,
    output logic      [7:0]             bus_data_o,
    output logic                        bus_intr_o,
    output logic                        vid_ena_o,
    output logic                        mem_req_o,
    output logic                        mem_wr_o,
    output logic      [15:0]            mem_addr_o,
    output logic      [15:0]            mem_wdata_o,
    output logic                        pal_wr_o,
    output logic      [PIX_W-1:0]       pal_idx_o,
    output logic      [COLOR_W-1:0]     pal_color_o
);

logic [7:0]  even_q;        // even byte waiting for its odd half
logic [15:0] word;          // assembled 16-bit value
logic [15:0] wr_addr;
logic [15:0] rd_addr;
logic [15:0] rd_data;
logic [15:0] rd_word;       // register selected for a bus read
logic        busy;
logic        wr_stb;
logic        rd_stb;
logic        odd_wr;
logic        mem_done;
xv_reg_e     reg_sel;
mem_op_e     op;

assign reg_sel  = xv_reg_e'(bus_reg_num_i);
assign wr_stb   = !bus_cs_n_i && (bus_rnw_e'(bus_rd_nwr_i) == BUS_WR);
assign rd_stb   = !bus_cs_n_i && (bus_rnw_e'(bus_rd_nwr_i) == BUS_RD);
assign odd_wr   = wr_stb && bus_bytesel_i;     // odd byte fires the action
assign word     = {even_q, bus_data_i};
assign mem_done = mem_req_o && mem_ack_i;       // ack seen
assign mem_wr_o = (op == MOP_WRITE);

// register read mux
always_comb begin
    rd_word = '0;
    case (reg_sel)
        XR_WR_ADDR: rd_word = wr_addr;
        XR_DATA:    rd_word = mem_wdata_o;
        XR_RD_ADDR: rd_word = rd_addr;
        XR_RD_DATA: rd_word = rd_data;
        XR_PAL:     rd_word = {pal_idx_o, pal_color_o};
        XR_CTRL:    rd_word[CTRL_ENA_BIT] = vid_ena_o;
        XR_STATUS: begin
            rd_word[STAT_BUSY_BIT]   = busy;
            rd_word[STAT_VBLANK_BIT] = vblank_i;
        end
        default: ;
    endcase
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        busy       <= 1'b0;
        mem_req_o  <= 1'b0;
        op         <= MOP_READ;
        wr_addr    <= '0;
        vid_ena_o  <= 1'b0;
        bus_intr_o <= 1'b0;
        pal_wr_o   <= 1'b0;
        bus_data_o <= '0;
    end else begin
        pal_wr_o <= 1'b0;                           // single cycle strobe
        if (busy && !mem_req_o && !mem_ack_i) begin
            mem_req_o <= 1'b1;                      // previous ack gone
        end
        if (mem_done) begin
            mem_req_o <= 1'b0;
            busy      <= 1'b0;
            if (op == MOP_WRITE) begin
                wr_addr <= wr_addr + 16'd1;         // auto increment
            end
        end
        if (rd_stb) begin
            bus_data_o <= bus_rd_byte(rd_word, bus_bytesel_i);
        end
        if (odd_wr) begin
            case (reg_sel)
                XR_WR_ADDR: wr_addr <= word;        // host write beats increment
                XR_DATA: begin
                    if (!busy) begin
                        busy <= 1'b1;
                        op   <= MOP_WRITE;
                    end
                end
                XR_RD_ADDR: begin
                    if (!busy) begin
                        busy <= 1'b1;
                        op   <= MOP_READ;
                    end
                end
                XR_PAL:  pal_wr_o <= 1'b1;
                XR_CTRL: begin
                    vid_ena_o <= word[CTRL_ENA_BIT];
                    if (word[CTRL_IACK_BIT]) begin
                        bus_intr_o <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
        if (vblank_start_i) begin
            bus_intr_o <= 1'b1;                     // new frame wins over ack
        end
    end
end

// data path registers
always_ff @(posedge clk) begin
    if (wr_stb && !bus_bytesel_i) begin
        even_q <= bus_data_i;
    end
    if (mem_done && op == MOP_READ) begin
        rd_data <= mem_rdata_i;
    end
    if (odd_wr) begin
        case (reg_sel)
            XR_DATA: begin
                if (!busy) begin
                    mem_wdata_o <= word;
                    mem_addr_o  <= wr_addr;         // held for the whole request
                end
            end
            XR_RD_ADDR: begin
                rd_addr <= word;
                if (!busy) begin
                    mem_addr_o <= word;
                end
            end
            XR_PAL: begin
                pal_idx_o   <= word[15 -: PIX_W];
                pal_color_o <= word[COLOR_W-1:0];
            end
            default: ;
        endcase
    end
end

// even byte on bytesel 0
function automatic logic [7:0] bus_rd_byte(logic [15:0] w, logic odd);
    bus_rd_byte = odd ? w[7:0] : w[15:8];
endfunction

endmodule

`default_nettype wire

// File: source/xv_vram_arb.sv
// single-port vram array with video fetch priority and host req/ack handshake
`default_nettype none
`timescale 1ns/10ps

module xv_vram_arb #(
    parameter int VRAM_AW = 16
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   vid_fetch_i,    // video owns this cycle
    input  wire logic [VRAM_AW-1:0]     vid_addr_i,
    input  wire logic                   mem_req_i,
    input  wire logic                   mem_wr_i,
    input  wire logic [VRAM_AW-1:0]     mem_addr_i,
    input  wire logic [15:0]            mem_wdata_i,
    output logic      [15:0]            vid_data_o,     // valid cycle after fetch
    output logic                        mem_ack_o,
    output logic      [15:0]            mem_rdata_o     // valid while ack first high
);

logic [15:0]        vram [2**VRAM_AW];
logic [VRAM_AW-1:0] addr;
logic [15:0]        rd_q;
logic               host_go;

// host gets the port only in a free cycle and once per request
assign host_go = mem_req_i && !mem_ack_o && !vid_fetch_i;
assign addr    = vid_fetch_i ? vid_addr_i : mem_addr_i;

always_ff @(posedge clk) begin
    if (host_go && mem_wr_i) begin
        vram[addr] <= mem_wdata_i;
    end
    rd_q <= vram[addr];     // one read port shared by both users
end

assign vid_data_o  = rd_q;
assign mem_rdata_o = rd_q;

// ack side of four-phase handshake
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        mem_ack_o <= 1'b0;
    end else if (host_go) begin
        mem_ack_o <= 1'b1;
    end else if (!mem_req_i) begin
        mem_ack_o <= 1'b0;  // drop only after req falls
    end
end

endmodule

`default_nettype wire

// File: source/xv_video_gen.sv
// scan timing, bitmap fetch address generation and pixel nibble shifter
`default_nettype none
`timescale 1ns/10ps

module xv_video_gen
    import xv_video_pkg::*;
#(
    parameter int H_VIS   = 640,
    parameter int H_FP    = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BP    = 48,
    parameter int V_VIS   = 480,
    parameter int V_FP    = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BP    = 33,
    parameter int VRAM_AW = 16
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   enable_i,
    input  wire logic [15:0]            vid_data_i,
    output logic                        vid_fetch_o,
    output logic      [VRAM_AW-1:0]     vid_addr_o,
    output logic      [PIX_W-1:0]       pix_idx_o,
    output logic                        de_o,
    output logic                        hsync_o,        // active low
    output logic                        vsync_o,        // active low
    output logic                        vblank_o,
    output logic                        vblank_start_o  // first cycle of vertical front porch
);

localparam int H_TOT = H_VIS + H_FP + H_SYNC + H_BP;
localparam int V_TOT = V_VIS + V_FP + V_SYNC + V_BP;
localparam int HW    = $clog2(H_TOT);
localparam int VW    = $clog2(V_TOT);
localparam logic [VRAM_AW-1:0] ROW_WORDS = VRAM_AW'(H_VIS / 4);    // 4 pixels per word

logic [HW-1:0]      h_cnt;
logic [VW-1:0]      v_cnt;
scan_phase_e        h_phase;
scan_phase_e        v_phase;
logic [VRAM_AW-1:0] row_base;       // first word of current line
logic               line_end;
logic               frame_end;
logic               vis_s0;         // visible at counter stage
logic [1:0]         de_p;           // 2 cycle delay to pixel stage
logic [1:0]         hs_p;
logic [1:0]         vs_p;
logic               load_q;         // fetched word arrives this cycle
logic [15:0]        pix_sh;

assign line_end    = (h_cnt == HW'(H_TOT - 1));
assign frame_end   = line_end && (v_cnt == VW'(V_TOT - 1));
assign vis_s0      = enable_i && (h_phase == SP_VISIBLE) && (v_phase == SP_VISIBLE);
assign vid_fetch_o = vis_s0 && (h_cnt[1:0] == 2'b00);  // every 4th pixel
assign vid_addr_o  = row_base + VRAM_AW'(h_cnt >> 2);
assign vblank_o    = (v_phase != SP_VISIBLE);

// phase after the counter leaves position cnt
function automatic scan_phase_e phase_step(scan_phase_e cur, int cnt, int vis, int fp,
                                           int sync, int tot);
    phase_step = cur;
    if (cnt == vis - 1)             phase_step = SP_FRONT;
    else if (cnt == vis + fp - 1)   phase_step = SP_SYNC;
    else if (cnt == vis + fp + sync - 1) phase_step = SP_BACK;
    else if (cnt == tot - 1)        phase_step = SP_VISIBLE;
endfunction

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        h_cnt          <= '0;
        v_cnt          <= '0;
        h_phase        <= SP_VISIBLE;
        v_phase        <= SP_VISIBLE;
        row_base       <= '0;
        vblank_start_o <= 1'b0;
        de_p           <= 2'b00;
        hs_p           <= 2'b11;
        vs_p           <= 2'b11;
        load_q         <= 1'b0;
    end else begin
        h_cnt   <= line_end ? '0 : h_cnt + 1'b1;
        h_phase <= phase_step(h_phase, int'(h_cnt), H_VIS, H_FP, H_SYNC, H_TOT);
        if (line_end) begin
            v_cnt   <= frame_end ? '0 : v_cnt + 1'b1;
            v_phase <= phase_step(v_phase, int'(v_cnt), V_VIS, V_FP, V_SYNC, V_TOT);
        end
        if (frame_end) begin
            row_base <= '0;
        end else if (line_end && v_phase == SP_VISIBLE) begin
            row_base <= row_base + ROW_WORDS;
        end
        vblank_start_o <= line_end && (v_cnt == VW'(V_VIS - 1));
        de_p   <= {de_p[0], vis_s0};
        hs_p   <= {hs_p[0], h_phase != SP_SYNC};
        vs_p   <= {vs_p[0], v_phase != SP_SYNC};
        load_q <= vid_fetch_o;
    end
end

// msb nibble goes out first
always_ff @(posedge clk) begin
    pix_sh <= load_q ? vid_data_i : {pix_sh[15-PIX_W:0], PIX_W'(0)};
end

assign pix_idx_o = pix_sh[15 -: PIX_W];
assign de_o      = de_p[1];
assign hsync_o   = hs_p[1];
assign vsync_o   = vs_p[1];

endmodule

`default_nettype wire

// File: source/xv_palette.sv
// 16 entry palette ram with registered rgb, display enable and sync outputs
`default_nettype none
`timescale 1ns/10ps

module xv_palette
    import xv_video_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   pal_wr_i,
    input  wire logic [PIX_W-1:0]       pal_idx_i,
    input  wire logic [COLOR_W-1:0]     pal_color_i,
    input  wire logic [PIX_W-1:0]       pix_idx_i,
    input  wire logic                   de_i,
    input  wire logic                   hsync_i,
    input  wire logic                   vsync_i,
    output logic      [3:0]             red_o,
    output logic      [3:0]             green_o,
    output logic      [3:0]             blue_o,
    output logic                        dv_de_o,
    output logic                        hsync_o,
    output logic                        vsync_o
);

logic [COLOR_W-1:0] pal_mem [2**PIX_W];
logic [COLOR_W-1:0] color;

always_ff @(posedge clk) begin
    if (pal_wr_i) begin
        pal_mem[pal_idx_i] <= pal_color_i;
    end
end

assign color = pal_mem[pix_idx_i];  // async lookup, registered below

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        {red_o, green_o, blue_o} <= '0;
        dv_de_o <= 1'b0;
        hsync_o <= 1'b1;            // syncs idle high
        vsync_o <= 1'b1;
    end else begin
        {red_o, green_o, blue_o} <= de_i ? color : '0;  // black in blanking
        dv_de_o <= de_i;
        hsync_o <= hsync_i;
        vsync_o <= vsync_i;
    end
end

endmodule

`default_nettype wire

// File: source/xv_main.sv
// top level with register block, vram arbiter, video generator and palette
`default_nettype none
`timescale 1ns/10ps

module xv_main
    import xv_video_pkg::*;
#(
    parameter int H_VIS   = 640,
    parameter int H_FP    = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BP    = 48,
    parameter int V_VIS   = 480,
    parameter int V_FP    = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BP    = 33,
    parameter int VRAM_AW = 16
) (
    input  wire logic           clk,                // pixel clock
    input  wire logic           rst_n_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,         // vblank irq
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

// host to vram handshake
logic               mem_req;
logic               mem_ack;
logic               mem_wr;
logic [15:0]        mem_addr;
logic [15:0]        mem_wdata;
logic [15:0]        mem_rdata;
// video fetch path
logic               vid_fetch;
logic [VRAM_AW-1:0] vid_addr;
logic [15:0]        vid_data;
logic               vid_ena;
// palette write and pixel stream
logic               pal_wr;
logic [PIX_W-1:0]   pal_idx;
logic [COLOR_W-1:0] pal_color;
logic [PIX_W-1:0]   pix_idx;
logic               vg_de;
logic               vg_hsync;
logic               vg_vsync;
logic               vblank;
logic               vblank_start;

xv_regs i_xv_regs (
    .clk(clk),                      .rst_n_i(rst_n_i),
    .bus_cs_n_i(bus_cs_n_i),        .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),  .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),        .mem_ack_i(mem_ack),
    .mem_rdata_i(mem_rdata),        .vblank_i(vblank),
    .vblank_start_i(vblank_start),  .bus_data_o(bus_data_o),
    .bus_intr_o(bus_intr_o),        .vid_ena_o(vid_ena),
    .mem_req_o(mem_req),            .mem_wr_o(mem_wr),
    .mem_addr_o(mem_addr),          .mem_wdata_o(mem_wdata),
    .pal_wr_o(pal_wr),              .pal_idx_o(pal_idx),
    .pal_color_o(pal_color)
);

xv_vram_arb #(.VRAM_AW(VRAM_AW)) i_xv_vram_arb (
    .clk(clk),                      .rst_n_i(rst_n_i),
    .vid_fetch_i(vid_fetch),        .vid_addr_i(vid_addr),
    .mem_req_i(mem_req),            .mem_wr_i(mem_wr),
    .mem_addr_i(mem_addr[VRAM_AW-1:0]),   // word address within vram
    .mem_wdata_i(mem_wdata),        .vid_data_o(vid_data),
    .mem_ack_o(mem_ack),            .mem_rdata_o(mem_rdata)
);

xv_video_gen #(
    .H_VIS(H_VIS), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_VIS(V_VIS), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .VRAM_AW(VRAM_AW)
) i_xv_video_gen (
    .clk(clk),                      .rst_n_i(rst_n_i),
    .enable_i(vid_ena),             .vid_data_i(vid_data),
    .vid_fetch_o(vid_fetch),        .vid_addr_o(vid_addr),
    .pix_idx_o(pix_idx),            .de_o(vg_de),
    .hsync_o(vg_hsync),             .vsync_o(vg_vsync),
    .vblank_o(vblank),              .vblank_start_o(vblank_start)
);

xv_palette i_xv_palette (
    .clk(clk),                      .rst_n_i(rst_n_i),
    .pal_wr_i(pal_wr),              .pal_idx_i(pal_idx),
    .pal_color_i(pal_color),        .pix_idx_i(pix_idx),
    .de_i(vg_de),                   .hsync_i(vg_hsync),
    .vsync_i(vg_vsync),             .red_o(red_o),
    .green_o(green_o),              .blue_o(blue_o),
    .dv_de_o(dv_de_o),              .hsync_o(hsync_o),
    .vsync_o(vsync_o)
);

endmodule

`default_nettype wire

// File: tb/tb_xv_main.sv
// testbench for xv_main with bus tasks, vram and palette models, frame checks and watchdog
`default_nettype none
`timescale 1ns/10ps

module tb_xv_main
    import xv_bus_pkg::*;
    import xv_video_pkg::*;
();

localparam int H_VIS  = 16;                         // tiny screen
localparam int H_FP   = 2;
localparam int H_SYNC = 3;
localparam int H_BP   = 2;
localparam int V_VIS  = 4;
localparam int V_FP   = 2;
localparam int V_SYNC = 3;
localparam int V_BP   = 2;
localparam int VRAM_AW   = 8;
localparam int CLK_PER   = 40;
localparam int H_TOT     = H_VIS + H_FP + H_SYNC + H_BP;
localparam int FRAME_CYC = H_TOT * (V_VIS + V_FP + V_SYNC + V_BP);
localparam int N_BUS_OPS = 120;                     // host transfers including busy polls
localparam int WATCHDOG_CYC = 4 * FRAME_CYC + 200 * N_BUS_OPS;
localparam int STIM_N  = 60;
localparam int SCR_OFS = 16;                        // screen words after the palette
localparam int BST_OFS = 32;
localparam int RB_OFS  = 36;                        // read-back pairs
localparam int N_RB    = 12;
localparam logic [15:0] CTRL_ACK_ENA = (16'd1 << CTRL_ENA_BIT) | (16'd1 << CTRL_IACK_BIT);

logic       clk;
logic       rst_n;
logic       bus_cs_n;
logic       bus_rd_nwr;
logic [3:0] bus_reg_num;
logic       bus_bytesel;
logic [7:0] bus_wdata;
logic [7:0] bus_rdata;
logic       intr;
logic [3:0] red;
logic [3:0] green;
logic [3:0] blue;
logic       hsync;
logic       vsync;
logic       dv_de;

logic [15:0]        stim [0:STIM_N-1];
logic [15:0]        vram_model [0:2**VRAM_AW-1];
logic [COLOR_W-1:0] pal_model [0:15];
int                 n_checks;
integer             seed;

xv_main #(
    .H_VIS(H_VIS), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_VIS(V_VIS), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .VRAM_AW(VRAM_AW)
) i_xv_main (
    .clk(clk),                  .rst_n_i(rst_n),
    .bus_cs_n_i(bus_cs_n),      .bus_rd_nwr_i(bus_rd_nwr),
    .bus_reg_num_i(bus_reg_num), .bus_bytesel_i(bus_bytesel),
    .bus_data_i(bus_wdata),     .bus_data_o(bus_rdata),
    .bus_intr_o(intr),          .red_o(red),
    .green_o(green),            .blue_o(blue),
    .hsync_o(hsync),            .vsync_o(vsync),
    .dv_de_o(dv_de)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PER / 2) clk = ~clk;
end

initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYC);
end

task automatic fail_now(input string what);
    $display("ERROR: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    n_checks++;
    if (act !== exp) begin
        $display("MISMATCH %s: expected 0x%04h, actual 0x%04h", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    end
endtask

task automatic check_color(input string name, input logic [COLOR_W-1:0] exp,
                           input logic [COLOR_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
        $display("MISMATCH %s: expected 0x%03h, actual 0x%03h", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
        $display("MISMATCH %s: expected %0b, actual %0b", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
        $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    end
endtask

// one select strobe that returns on the falling edge after it
task automatic bus_strobe(input bus_rnw_e rnw, input xv_reg_e reg_num, input logic odd,
                          input logic [7:0] data);
    @(negedge clk);
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = rnw;
    bus_reg_num = reg_num;
    bus_bytesel = odd;
    bus_wdata   = data;
    @(negedge clk);
    bus_cs_n    = 1'b1;     // read byte is out now
endtask

task automatic bus_write(input xv_reg_e reg_num, input logic [15:0] data);
    bus_strobe(BUS_WR, reg_num, 1'b0, data[15:8]);
    bus_strobe(BUS_WR, reg_num, 1'b1, data[7:0]);  // odd byte fires
endtask

task automatic bus_read(input xv_reg_e reg_num, output logic [15:0] data);
    bus_strobe(BUS_RD, reg_num, 1'b0, 8'h00);
    data[15:8] = bus_rdata;
    bus_strobe(BUS_RD, reg_num, 1'b1, 8'h00);
    data[7:0] = bus_rdata;
endtask

// poll status until the vram access is done
task automatic wait_idle();
    logic [15:0] st;
    int          polls;
    polls = 0;
    bus_read(XR_STATUS, st);
    while (st[STAT_BUSY_BIT]) begin
        polls++;
        if (polls > 50) fail_now("status busy bit never cleared");
        bus_read(XR_STATUS, st);
    end
endtask

task automatic write_burst(input logic [15:0] base, input int ofs, input int n);
    wait_idle();
    bus_write(XR_WR_ADDR, base);                   // single address then data only
    for (int i = 0; i < n; i++) begin
        wait_idle();
        bus_write(XR_DATA, stim[ofs + i]);
        vram_model[base[VRAM_AW-1:0] + VRAM_AW'(i)] = stim[ofs + i];
    end
endtask

task automatic wait_vsync_rise();
    logic prev;
    prev = vsync;
    for (int n = 0; n < 2 * FRAME_CYC; n++) begin
        @(negedge clk);
        if (vsync && !prev) return;
        prev = vsync;
    end
    fail_now("vsync_o did not rise within two frames");
endtask

// horizontal phase from the column counted since hsync fell
function automatic scan_phase_e phase_at(input int hcol);
    if (hcol < H_SYNC) return SP_SYNC;
    if (hcol < H_SYNC + H_BP) return SP_BACK;
    if (hcol < H_SYNC + H_BP + H_VIS) return SP_VISIBLE;
    return SP_FRONT;
endfunction

// one whole frame from vsync rise with pixels against the models
task automatic check_frame(input logic video_on);
    logic [15:0] w;
    logic [3:0]  nib;
    logic        hs_prev;
    logic        vs_fell;
    scan_phase_e ph;
    int          pix;
    int          col;
    int          line_de;
    int          de_lines;
    int          hs_low;
    int          hcol;
    pix = 0;
    line_de = 0;
    de_lines = 0;
    hs_low = 0;
    hs_prev = 1'b1;
    vs_fell = 1'b0;
    wait_vsync_rise();
    hcol = H_SYNC + H_BP;                          // frame opens at a line's first pixel
    for (int c = 0; c < FRAME_CYC; c++) begin
        if (!hsync && hs_prev) hcol = 0;
        if (!hsync) begin
            hs_low++;
        end else if (hs_low != 0) begin
            check_count("hsync low width", H_SYNC, hs_low);
            hs_low = 0;
        end
        if (!vsync) vs_fell = 1'b1;
        if (dv_de) begin
            if (!video_on) check_flag("dv_de_o with video disabled", 1'b0, dv_de);
            col = pix % H_VIS;
            w   = vram_model[VRAM_AW'((pix / H_VIS) * (H_VIS / 4) + col / 4)];
            nib = w[(3 - col % 4) * 4 +: 4];       // leftmost pixel in top nibble
            check_color($sformatf("pixel %0d", pix), pal_model[nib], {red, green, blue});
            pix++;
            line_de++;
        end else begin
            ph = phase_at(hcol);
            check_color($sformatf("blank rgb in %s", ph.name()), '0, {red, green, blue});
            if (line_de != 0) begin
                check_count("de cycles per line", H_VIS, line_de);
                de_lines++;
                line_de = 0;
            end
        end
        hs_prev = hsync;
        hcol++;
        @(negedge clk);
    end
    if (video_on) check_count("lines with de per frame", V_VIS, de_lines);
    check_flag("vsync_o low within the frame", 1'b1, vs_fell);
endtask

task automatic check_irq();
    logic [15:0] st;
    int          de_cnt;
    int          n;
    wait_vsync_rise();
    bus_write(XR_CTRL, CTRL_ACK_ENA);              // clear flags from earlier frames
    check_flag("bus_intr_o after first acknowledge", 1'b0, intr);
    de_cnt = 0;
    n = 0;
    while (!intr) begin
        if (dv_de) de_cnt++;
        n++;
        if (n > FRAME_CYC) fail_now("bus_intr_o did not rise within a frame");
        @(negedge clk);
    end
    check_count("de cycles before interrupt", H_VIS * V_VIS, de_cnt);
    for (n = 0; n < H_TOT; n++) begin
        @(negedge clk);
        check_flag("bus_intr_o holds in blanking", 1'b1, intr);
    end
    bus_read(XR_STATUS, st);
    check_flag("vblank status bit", 1'b1, st[STAT_VBLANK_BIT]);
    bus_write(XR_CTRL, CTRL_ACK_ENA);
    check_flag("bus_intr_o after acknowledge", 1'b0, intr);
endtask

initial begin
    logic [15:0] a;
    logic [15:0] got;
    int          order [N_RB];
    int          j;
    int          t;
    rst_n = 1'b0;
    bus_cs_n = 1'b1;
    bus_rd_nwr = BUS_RD;
    bus_reg_num = 4'h0;
    bus_bytesel = 1'b0;
    bus_wdata = 8'h00;
    n_checks = 0;
    seed = 66;
    $readmemh("tb/xv_stimulus.txt", stim);
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 16; i++) begin             // palette entries with index in top nibble
        bus_write(XR_PAL, {PIX_W'(i), stim[i][COLOR_W-1:0]});
        pal_model[i] = stim[i][COLOR_W-1:0];
    end
    write_burst(16'h0000, SCR_OFS, H_VIS / 4 * V_VIS);
    write_burst(16'h0040, BST_OFS, 4);

    for (int i = 0; i < N_RB; i++) order[i] = i;
    for (int i = N_RB - 1; i > 0; i--) begin       // shuffle read-back order
        j = int'($unsigned($random(seed)) % (i + 1));
        t = order[i];
        order[i] = order[j];
        order[j] = t;
    end
    for (int k = 0; k < N_RB; k++) begin
        a = stim[RB_OFS + 2 * order[k]];
        wait_idle();
        bus_write(XR_RD_ADDR, a);
        wait_idle();
        bus_read(XR_RD_DATA, got);
        if (vram_model[a[VRAM_AW-1:0]] !== stim[RB_OFS + 2 * order[k] + 1])
            fail_now($sformatf("stimulus expects other data at 0x%02h than was written", a));
        check_word($sformatf("readback 0x%02h", a), stim[RB_OFS + 2 * order[k] + 1], got);
    end

    bus_write(XR_CTRL, 16'd1 << CTRL_ENA_BIT);
    check_frame(1'b1);
    check_irq();
    bus_write(XR_CTRL, 16'h0000);                  // video off while syncs keep going
    check_frame(1'b0);

    if (n_checks > 0) begin
        $display("Simulation PASSED");
        $finish;
    end else begin
        $display("Simulation FAILED");
        $fatal(1, "no check was executed");
    end
end

endmodule

`default_nettype wire

// File: xv_main.f
source/xv_bus_pkg.sv
source/xv_video_pkg.sv
source/xv_regs.sv
source/xv_vram_arb.sv
source/xv_video_gen.sv
source/xv_palette.sv
source/xv_main.sv
tb/tb_xv_main.sv

// File: run_sim.sh
#!/bin/bash
# build the xv_main testbench with verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -Wno-fatal -f xv_main.f --top-module tb_xv_main -o tb_xv_main \
    > sim.log 2>&1 \
    && ./obj_dir/tb_xv_main >> sim.log 2>&1 \
    || echo "Simulation FAILED" >> sim.log

cat sim.log
if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

// File: tb/xv_stimulus.txt
// one hex word per entry: 16 palette colours (0xRGB), 16 screen words from address 0x00,
// 4 burst words from address 0x40, then 12 read-back pairs of address and expected word
// palette entries 0-15
111 F00 0F0 00F
FF0 0FF F0F 888
123 456 789 ABC
DEF 2A5 C3E 7B1
// screen words, one line of pixels per row
0123 4567 89AB CDEF
FEDC BA98 7654 3210
1F2E 3D4C 5B6A 7980
A5A5 5A5A 0F0F C3C3
// burst at 0x40
BEEF 1234 CAFE 0042
// read-back address and expected word
0040 BEEF
0003 CDEF
0041 1234
0007 3210
000A 5B6A
0043 0042
0000 0123
000F C3C3
0042 CAFE
0005 BA98
000C A5A5
0009 3D4C
